//--- source/agp32_pkg.sv
package agp32_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_bits = 6;
  localparam int in_bits = 2;
  localparam int out_bits = 10;

  // Opcode 15 decodes as a NOP.
  localparam logic [xlen-1:0] nop_inst = 32'd15;

  typedef enum logic [5:0] {
    opc_alu          = 6'd0,
    opc_shift        = 6'd1,
    opc_out          = 6'd6,
    opc_in           = 6'd7,
    opc_jump         = 6'd9,
    opc_jump_zero    = 6'd10,
    opc_jump_nonzero = 6'd11,
    opc_load_const   = 6'd13,
    opc_load_upper   = 6'd14,
    opc_nop          = 6'd15
  } opc_t;

  typedef enum logic [3:0] {
    func_add    = 4'd0,
    func_addc   = 4'd1,
    func_sub    = 4'd2,
    func_rdc    = 4'd3,
    func_rdo    = 4'd4,
    func_inc    = 4'd5,
    func_dec    = 4'd6,
    func_mul_lo = 4'd7,
    func_mul_hi = 4'd8,
    func_and    = 4'd9,
    func_or     = 4'd10,
    func_xor    = 4'd11,
    func_eq     = 4'd12,
    func_lt     = 4'd13,
    func_ltu    = 4'd14,
    func_passb  = 4'd15
  } func_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] inst;
  } if_id_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    opc_t opc;
    func_t func;
    logic [xlen-1:0] data_a;
    logic [xlen-1:0] data_b;
    logic [xlen-1:0] data_w;
    logic [xlen-1:0] imm;
    logic [reg_addr_bits-1:0] addr_a;
    logic [reg_addr_bits-1:0] addr_b;
    logic [reg_addr_bits-1:0] addr_w;
    logic imm_a;                    // Operand field holds an immediate.
    logic imm_b;
    logic imm_w;
  } id_ex_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    opc_t opc;
    logic [reg_addr_bits-1:0] addr_w;
    logic reg_write;
    logic [xlen-1:0] alu_res;
    logic [xlen-1:0] shift_res;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] data_w;        // Forwarded W, needed by load-upper.
  } ex_res_t;

  typedef struct packed {
    logic [reg_addr_bits-1:0] addr_w;
    logic reg_write;
    logic [xlen-1:0] data;
    logic is_out;
  } res_wb_t;

  typedef enum logic [1:0] {
    fwd_none,
    fwd_res,
    fwd_wb
  } fwd_t;

endpackage

//--- source/agp32_pipe_reg.sv
`timescale 1ns/1ps

module agp32_pipe_reg #(
  parameter type payload_t = logic
) (
  input logic clk,
  input logic reset,
  input logic advance,
  input logic flush,
  input logic in_valid,
  input payload_t in_data,
  output logic out_valid,
  output payload_t out_data
);

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
      out_data <= '0;
    end else if (advance) begin
      out_valid <= in_valid && !flush;   // A flushed slot becomes a bubble.
      out_data <= in_data;
    end
  end

endmodule

//--- source/agp32_regfile.sv
`timescale 1ns/1ps

module agp32_regfile (
  input logic clk,
  input logic [agp32_pkg::reg_addr_bits-1:0] addr_a,
  input logic [agp32_pkg::reg_addr_bits-1:0] addr_b,
  input logic [agp32_pkg::reg_addr_bits-1:0] addr_w,
  input agp32_pkg::res_wb_t wb,
  input logic wb_valid,
  output logic [agp32_pkg::xlen-1:0] data_a,
  output logic [agp32_pkg::xlen-1:0] data_b,
  output logic [agp32_pkg::xlen-1:0] data_w
);
  import agp32_pkg::*;

  logic [xlen-1:0] regs [0:(1 << reg_addr_bits)-1];
  logic write_en;

  assign write_en = wb_valid && wb.reg_write;

  always_ff @(posedge clk) begin
    if (write_en) begin
      regs[wb.addr_w] <= wb.data;
    end
  end

  // Write-through, so decode sees the value that writeback stores this cycle.
  assign data_a = (write_en && wb.addr_w == addr_a) ? wb.data : regs[addr_a];
  assign data_b = (write_en && wb.addr_w == addr_b) ? wb.data : regs[addr_b];
  assign data_w = (write_en && wb.addr_w == addr_w) ? wb.data : regs[addr_w];

endmodule

//--- source/agp32_alu.sv
`timescale 1ns/1ps

module agp32_alu (
  input logic clk,
  input logic reset,
  input logic advance,
  input agp32_pkg::func_t func,
  input logic [agp32_pkg::xlen-1:0] in1,
  input logic [agp32_pkg::xlen-1:0] in2,
  output logic [agp32_pkg::xlen-1:0] result
);
  import agp32_pkg::*;

  logic carry_flag;
  logic overflow_flag;
  logic [xlen:0] sum;
  logic [xlen-1:0] diff;
  logic [2*xlen-1:0] prod;
  logic add_ovf;
  logic sub_ovf;

  // Add-with-carry folds the stored carry into the same adder.
  assign sum = {1'b0, in1} + {1'b0, in2} + {{xlen{1'b0}}, (func == func_addc) && carry_flag};
  assign diff = in1 - in2;
  assign prod = {{xlen{1'b0}}, in1} * {{xlen{1'b0}}, in2};
  assign add_ovf = (in1[xlen-1] == in2[xlen-1]) && (sum[xlen-1] != in1[xlen-1]);
  assign sub_ovf = (in1[xlen-1] != in2[xlen-1]) && (diff[xlen-1] != in1[xlen-1]);

  always_comb begin
    case (func)
      func_add, func_addc: result = sum[xlen-1:0];
      func_sub: result = diff;
      func_rdc: result = {{(xlen-1){1'b0}}, carry_flag};
      func_rdo: result = {{(xlen-1){1'b0}}, overflow_flag};
      func_inc: result = in1 + 32'd1;
      func_dec: result = in1 - 32'd1;
      func_mul_lo: result = prod[xlen-1:0];
      func_mul_hi: result = prod[2*xlen-1:xlen];
      func_and: result = in1 & in2;
      func_or: result = in1 | in2;
      func_xor: result = in1 ^ in2;
      func_eq: result = {{(xlen-1){1'b0}}, in1 == in2};
      func_lt: result = {{(xlen-1){1'b0}}, $signed(in1) < $signed(in2)};
      func_ltu: result = {{(xlen-1){1'b0}}, in1 < in2};
      default: result = in2;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      carry_flag <= 1'b0;
      overflow_flag <= 1'b0;
    end else if (advance) begin
      case (func)
        func_add: begin
          carry_flag <= sum[xlen];
          overflow_flag <= add_ovf;
        end
        func_addc: carry_flag <= sum[xlen];
        func_sub: overflow_flag <= sub_ovf;   // Subtract leaves the carry alone.
        default: ;
      endcase
    end
  end

endmodule

//--- source/agp32_fetch.sv
`timescale 1ns/1ps

module agp32_fetch (
  input logic clk,
  input logic reset,
  input logic ready,
  input logic [agp32_pkg::xlen-1:0] inst_rdata,
  input logic jump_taken,
  input logic [agp32_pkg::xlen-1:0] jump_target,
  output logic [agp32_pkg::xlen-1:0] pc,
  output agp32_pkg::if_id_t if_id,
  output logic if_id_valid
);
  import agp32_pkg::*;

  logic [xlen-1:0] pc_next;
  if_id_t fetched;

  assign pc_next = jump_taken ? jump_target : pc + 32'd4;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (ready) begin
      pc <= pc_next;
    end
  end

  always_comb begin
    fetched.pc = pc;
    fetched.inst = inst_rdata;
  end

  // The word being fetched is squashed when execute takes a jump.
  agp32_pipe_reg #(.payload_t(if_id_t)) if_id_reg (
    .clk(clk),
    .reset(reset),
    .advance(ready),
    .flush(jump_taken),
    .in_valid(1'b1),
    .in_data(fetched),
    .out_valid(if_id_valid),
    .out_data(if_id)
  );

endmodule

//--- source/agp32_decode.sv
`timescale 1ns/1ps

module agp32_decode (
  input logic clk,
  input agp32_pkg::if_id_t if_id,
  input logic if_id_valid,
  input agp32_pkg::res_wb_t wb,
  input logic wb_valid,
  output agp32_pkg::id_ex_t id_ex,
  output logic id_ex_valid
);
  import agp32_pkg::*;

  logic [xlen-1:0] inst;
  logic [5:0] raw_opc;
  opc_t opc;
  func_t func;
  logic [xlen-1:0] imm;
  logic [xlen-1:0] rf_a;
  logic [xlen-1:0] rf_b;
  logic [xlen-1:0] rf_w;

  function automatic logic [xlen-1:0] sext6(input logic [5:0] field);
    return {{(xlen-6){field[5]}}, field};
  endfunction

  assign inst = if_id.inst;
  assign raw_opc = inst[5:0];

  agp32_regfile regfile (
    .clk(clk),
    .addr_a(inst[22:17]),
    .addr_b(inst[15:10]),
    .addr_w(inst[30:25]),
    .wb(wb),
    .wb_valid(wb_valid),
    .data_a(rf_a),
    .data_b(rf_b),
    .data_w(rf_w)
  );

  always_comb begin
    opc = opc_nop;
    if (inst[24]) begin
      if (inst[31]) begin
        opc = opc_load_const;
      end else if (inst[23:9] == '0) begin
        opc = opc_load_upper;
      end
    end else if (raw_opc == 6'd10 || raw_opc == 6'd11 || (!inst[31] && raw_opc < 6'd10)) begin
      case (raw_opc)
        6'd0, 6'd1, 6'd6, 6'd7, 6'd9, 6'd10, 6'd11: opc = opc_t'(raw_opc);
        default: opc = opc_nop;   // Memory and accelerator opcodes are not built.
      endcase
    end
  end

  // A shift keeps its mode in the low two func bits.
  always_comb begin
    case (opc)
      opc_alu, opc_out, opc_jump, opc_jump_zero, opc_jump_nonzero: func = func_t'(inst[9:6]);
      opc_shift: func = func_t'({2'b11, inst[7:6]});
      default: func = func_and;
    endcase
  end

  always_comb begin
    imm = '0;
    if (opc == opc_load_const) begin
      imm = inst[23] ? 32'd0 - {9'd0, inst[22:0]} : {9'd0, inst[22:0]};
    end else if (opc == opc_load_upper) begin
      imm = {23'd0, inst[8:0]};
    end
  end

  always_comb begin
    id_ex.pc = if_id.pc;
    id_ex.opc = opc;
    id_ex.func = func;
    id_ex.imm = imm;
    id_ex.addr_a = inst[22:17];
    id_ex.addr_b = inst[15:10];
    id_ex.addr_w = inst[30:25];
    id_ex.imm_a = inst[23];
    id_ex.imm_b = inst[16];
    id_ex.imm_w = inst[31];
    id_ex.data_a = inst[23] ? sext6(inst[22:17]) : rf_a;
    id_ex.data_b = inst[16] ? sext6(inst[15:10]) : rf_b;
    id_ex.data_w = inst[31] ? sext6(inst[30:25]) : rf_w;
  end

  assign id_ex_valid = if_id_valid;

endmodule

//--- source/agp32_execute.sv
`timescale 1ns/1ps

module agp32_execute (
  input logic clk,
  input logic reset,
  input logic ready,
  input agp32_pkg::id_ex_t id_ex,
  input logic id_ex_valid,
  input agp32_pkg::res_wb_t res_fwd,
  input logic res_fwd_valid,
  input agp32_pkg::res_wb_t wb_fwd,
  input logic wb_fwd_valid,
  output agp32_pkg::ex_res_t ex_res,
  output logic ex_res_valid,
  output logic jump_taken,
  output logic [agp32_pkg::xlen-1:0] jump_target
);
  import agp32_pkg::*;

  id_ex_t cur;
  logic cur_valid;
  logic reads_a, reads_b, reads_w;
  logic res_live, wb_live;
  fwd_t sel_a, sel_b, sel_w;
  logic [xlen-1:0] op_a, op_b, op_w;
  logic [xlen-1:0] alu_in1, alu_in2, alu_res;
  logic alu_advance;
  logic [2*xlen-1:0] rot;
  logic [xlen-1:0] shift_res;
  ex_res_t ex_next;

  // The result stage is younger than writeback, so it wins on a double hit.
  function automatic fwd_t pick_src(input logic used, input logic res_hit, input logic wb_hit);
    if (!used) return fwd_none;
    if (res_hit) return fwd_res;
    if (wb_hit) return fwd_wb;
    return fwd_none;
  endfunction

  function automatic logic [xlen-1:0] fwd_mux(input fwd_t sel, input logic [xlen-1:0] dec,
                                              input logic [xlen-1:0] res,
                                              input logic [xlen-1:0] wbv);
    case (sel)
      fwd_res: return res;
      fwd_wb: return wbv;
      default: return dec;
    endcase
  endfunction

  agp32_pipe_reg #(.payload_t(id_ex_t)) id_ex_reg (
    .clk(clk),
    .reset(reset),
    .advance(ready),
    .flush(jump_taken),
    .in_valid(id_ex_valid),
    .in_data(id_ex),
    .out_valid(cur_valid),
    .out_data(cur)
  );

  always_comb begin
    reads_a = cur.opc inside {opc_alu, opc_shift, opc_out, opc_jump, opc_jump_zero,
                              opc_jump_nonzero};
    reads_b = cur.opc inside {opc_alu, opc_shift, opc_out, opc_jump_zero, opc_jump_nonzero};
    reads_w = cur.opc inside {opc_jump_zero, opc_jump_nonzero, opc_load_upper};
  end

  assign res_live = res_fwd_valid && res_fwd.reg_write;
  assign wb_live = wb_fwd_valid && wb_fwd.reg_write;
  assign sel_a = pick_src(reads_a && !cur.imm_a, res_live && res_fwd.addr_w == cur.addr_a,
                          wb_live && wb_fwd.addr_w == cur.addr_a);
  assign sel_b = pick_src(reads_b && !cur.imm_b, res_live && res_fwd.addr_w == cur.addr_b,
                          wb_live && wb_fwd.addr_w == cur.addr_b);
  assign sel_w = pick_src(reads_w && !cur.imm_w, res_live && res_fwd.addr_w == cur.addr_w,
                          wb_live && wb_fwd.addr_w == cur.addr_w);
  assign op_a = fwd_mux(sel_a, cur.data_a, res_fwd.data, wb_fwd.data);
  assign op_b = fwd_mux(sel_b, cur.data_b, res_fwd.data, wb_fwd.data);
  assign op_w = fwd_mux(sel_w, cur.data_w, res_fwd.data, wb_fwd.data);

  always_comb begin
    rot = {op_a, op_a} >> op_b[4:0];
    case (cur.func[1:0])
      2'd0: shift_res = op_a << op_b;
      2'd1: shift_res = op_a >> op_b;
      2'd2: shift_res = $signed(op_a) >>> op_b;
      default: shift_res = rot[xlen-1:0];
    endcase
  end

  // Jump-and-link computes its target from PC and A.
  assign alu_in1 = (cur.opc == opc_jump) ? cur.pc : op_a;
  assign alu_in2 = (cur.opc == opc_jump) ? op_a : op_b;
  assign alu_advance = ready && cur_valid && (cur.opc == opc_alu || cur.opc == opc_out);

  agp32_alu alu (
    .clk(clk),
    .reset(reset),
    .advance(alu_advance),
    .func(cur.func),
    .in1(alu_in1),
    .in2(alu_in2),
    .result(alu_res)
  );

  always_comb begin
    jump_target = (cur.opc == opc_jump) ? alu_res : cur.pc + op_w;
    case (cur.opc)
      opc_jump: jump_taken = cur_valid;
      opc_jump_zero: jump_taken = cur_valid && alu_res == '0;
      opc_jump_nonzero: jump_taken = cur_valid && alu_res != '0;
      default: jump_taken = 1'b0;
    endcase
  end

  always_comb begin
    ex_next.pc = cur.pc;
    ex_next.opc = cur.opc;
    ex_next.addr_w = cur.addr_w;
    ex_next.reg_write = cur.opc inside {opc_alu, opc_shift, opc_out, opc_in, opc_jump,
                                        opc_load_const, opc_load_upper};
    ex_next.alu_res = alu_res;
    ex_next.shift_res = shift_res;
    ex_next.imm = cur.imm;
    ex_next.data_w = op_w;
  end

  agp32_pipe_reg #(.payload_t(ex_res_t)) ex_res_reg (
    .clk(clk),
    .reset(reset),
    .advance(ready),
    .flush(1'b0),
    .in_valid(cur_valid),
    .in_data(ex_next),
    .out_valid(ex_res_valid),
    .out_data(ex_res)
  );

endmodule

//--- source/agp32_writeback.sv
`timescale 1ns/1ps

module agp32_writeback (
  input logic clk,
  input logic reset,
  input logic ready,
  input agp32_pkg::ex_res_t ex_res,
  input logic ex_res_valid,
  input logic [agp32_pkg::in_bits-1:0] data_in,
  output agp32_pkg::res_wb_t res_fwd,
  output logic res_fwd_valid,
  output agp32_pkg::res_wb_t wb,
  output logic wb_valid,
  output logic [agp32_pkg::out_bits-1:0] data_out
);
  import agp32_pkg::*;

  logic [xlen-1:0] upper_val;

  // Load-upper keeps the low 23 bits of register W.
  assign upper_val = {ex_res.imm[8:0], ex_res.data_w[22:0]};

  always_comb begin
    res_fwd.addr_w = ex_res.addr_w;
    res_fwd.reg_write = ex_res.reg_write;
    res_fwd.is_out = ex_res.opc == opc_out;
    case (ex_res.opc)
      opc_shift: res_fwd.data = ex_res.shift_res;
      opc_in: res_fwd.data = {{(xlen-in_bits){1'b0}}, data_in};
      opc_jump: res_fwd.data = ex_res.pc + 32'd4;     // Link address.
      opc_load_const: res_fwd.data = ex_res.imm;
      opc_load_upper: res_fwd.data = upper_val;
      default: res_fwd.data = ex_res.alu_res;
    endcase
  end

  assign res_fwd_valid = ex_res_valid;

  agp32_pipe_reg #(.payload_t(res_wb_t)) wb_reg (
    .clk(clk),
    .reset(reset),
    .advance(ready),
    .flush(1'b0),
    .in_valid(ex_res_valid),
    .in_data(res_fwd),
    .out_valid(wb_valid),
    .out_data(wb)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      data_out <= '0;
    end else if (ready && wb_valid && wb.is_out) begin
      data_out <= wb.data[out_bits-1:0];
    end
  end

endmodule

//--- source/agp32_core.sv
`timescale 1ns/1ps

module agp32_core (
  input logic clk,
  input logic reset,
  input logic ready,
  input logic [agp32_pkg::xlen-1:0] inst_rdata,
  input logic [agp32_pkg::in_bits-1:0] data_in,
  output logic [agp32_pkg::xlen-1:0] pc,
  output logic [agp32_pkg::out_bits-1:0] data_out
);
  import agp32_pkg::*;

  if_id_t if_id;
  logic if_id_valid;
  id_ex_t id_ex;
  logic id_ex_valid;
  ex_res_t ex_res;
  logic ex_res_valid;
  res_wb_t res_fwd;
  logic res_fwd_valid;
  res_wb_t wb;
  logic wb_valid;
  logic jump_taken;
  logic [xlen-1:0] jump_target;

  agp32_fetch fetch (
    .clk(clk),
    .reset(reset),
    .ready(ready),
    .inst_rdata(inst_rdata),
    .jump_taken(jump_taken),
    .jump_target(jump_target),
    .pc(pc),
    .if_id(if_id),
    .if_id_valid(if_id_valid)
  );

  agp32_decode decode (
    .clk(clk),
    .if_id(if_id),
    .if_id_valid(if_id_valid),
    .wb(wb),
    .wb_valid(wb_valid),
    .id_ex(id_ex),
    .id_ex_valid(id_ex_valid)
  );

  agp32_execute execute (
    .clk(clk),
    .reset(reset),
    .ready(ready),
    .id_ex(id_ex),
    .id_ex_valid(id_ex_valid),
    .res_fwd(res_fwd),
    .res_fwd_valid(res_fwd_valid),
    .wb_fwd(wb),
    .wb_fwd_valid(wb_valid),
    .ex_res(ex_res),
    .ex_res_valid(ex_res_valid),
    .jump_taken(jump_taken),
    .jump_target(jump_target)
  );

  // Holds both the result stage and the writeback register.
  agp32_writeback writeback (
    .clk(clk),
    .reset(reset),
    .ready(ready),
    .ex_res(ex_res),
    .ex_res_valid(ex_res_valid),
    .data_in(data_in),
    .res_fwd(res_fwd),
    .res_fwd_valid(res_fwd_valid),
    .wb(wb),
    .wb_valid(wb_valid),
    .data_out(data_out)
  );

endmodule

//--- verification/agp32_programs.svh
task automatic fill_program_table();
  int k;
  for (k = 0; k < num_programs; k++) begin
    prog_len[k] = 0;
    exp_len[k] = 0;
    random_ready[k] = 1'b0;
  end

  // Dependent ALU chain, each step reading the previous destination.
  add_inst(0, load_const(1, 100, 0));
  add_inst(0, alu_ri(func_add, 2, 1, 5));
  add_inst(0, out_reg(2));                        expect_out(0, 105);
  add_inst(0, alu_ri(func_sub, 3, 2, 7));
  add_inst(0, out_reg(3));                        expect_out(0, 98);
  add_inst(0, alu_rr(func_mul_lo, 4, 3, 2));
  add_inst(0, out_reg(4));                        expect_out(0, 50);    // 10290 mod 1024.
  add_inst(0, load_const(5, 'h400000, 0));
  add_inst(0, alu_rr(func_mul_hi, 6, 5, 4));
  add_inst(0, out_reg(6));                        expect_out(0, 10);
  add_inst(0, alu_rr(func_and, 7, 4, 6));
  add_inst(0, out_reg(7));                        expect_out(0, 2);
  add_inst(0, alu_ri(func_or, 8, 7, 12));
  add_inst(0, out_reg(8));                        expect_out(0, 14);
  add_inst(0, alu_rr(func_xor, 9, 8, 6));
  add_inst(0, out_reg(9));                        expect_out(0, 4);
  add_inst(0, alu_ri(func_ltu, 10, 9, -1));
  add_inst(0, out_reg(10));                       expect_out(0, 1);
  add_inst(0, alu_ri(func_lt, 11, 10, -2));
  add_inst(0, out_reg(11));                       expect_out(0, 0);
  add_inst(0, alu_ri(func_eq, 12, 11, 0));
  add_inst(0, out_reg(12));                       expect_out(0, 1);
  add_inst(0, alu_ri(func_inc, 13, 12, 0));
  add_inst(0, out_reg(13));                       expect_out(0, 2);

  // Shifts, flags and the input port.
  add_inst(1, load_const(1, 'h50, 0));
  add_inst(1, shift_ri(0, 2, 1, 2));
  add_inst(1, out_reg(2));                        expect_out(1, 320);
  add_inst(1, shift_ri(1, 3, 2, 3));
  add_inst(1, out_reg(3));                        expect_out(1, 40);
  add_inst(1, load_const(4, 'h100, 1));
  add_inst(1, shift_ri(2, 5, 4, 4));
  add_inst(1, out_reg(5));                        expect_out(1, 1008);
  add_inst(1, shift_ri(3, 6, 1, 4));
  add_inst(1, out_reg(6));                        expect_out(1, 5);
  add_inst(1, shift_ri(3, 7, 6, 1));              // Low bit wraps to bit 31.
  add_inst(1, shift_ri(1, 8, 7, 22));
  add_inst(1, out_reg(8));                        expect_out(1, 512);
  add_inst(1, load_const(10, 'h7fffff, 0));
  add_inst(1, load_upper(10, 'h0ff));
  add_inst(1, alu_ri(func_add, 11, 10, 1));       // Signed overflow, no carry.
  add_inst(1, out_reg(10));                       expect_out(1, 1023);
  add_inst(1, alu_ii(func_rdo, 12, 0, 0));
  add_inst(1, out_reg(12));                       expect_out(1, 1);
  add_inst(1, alu_ii(func_rdc, 13, 0, 0));
  add_inst(1, out_reg(13));                       expect_out(1, 0);
  add_inst(1, load_const(14, 1, 1));
  add_inst(1, alu_ri(func_add, 15, 14, 2));       // Carry out, no overflow.
  add_inst(1, alu_ii(func_rdc, 17, 0, 0));
  add_inst(1, alu_ii(func_addc, 16, 3, 4));
  add_inst(1, out_reg(16));                       expect_out(1, 8);
  add_inst(1, out_reg(17));                       expect_out(1, 1);
  add_inst(1, alu_ii(func_rdo, 18, 0, 0));
  add_inst(1, out_reg(18));                       expect_out(1, 0);
  add_inst(1, read_input(19));
  add_inst(1, out_reg(19));                       expect_out(1, input_value);

  // Constants and load-upper.
  add_inst(2, load_const(1, 300, 0));
  add_inst(2, out_reg(1));                        expect_out(2, 300);
  add_inst(2, load_const(2, 5, 1));
  add_inst(2, out_reg(2));                        expect_out(2, 1019);
  add_inst(2, load_const(3, 'h12345, 0));
  add_inst(2, out_reg(3));                        expect_out(2, 837);
  add_inst(2, load_upper(3, 'h1ab));
  add_inst(2, shift_ri(1, 4, 3, 23));
  add_inst(2, out_reg(4));                        expect_out(2, 427);
  add_inst(2, load_const(5, 1, 1));
  add_inst(2, load_upper(5, 5));
  add_inst(2, out_reg(5));                        expect_out(2, 1023);
  add_inst(2, shift_ri(1, 6, 5, 20));
  add_inst(2, out_reg(6));                        expect_out(2, 47);

  // Conditional jumps. Values 27 to 30 sit in skipped slots.
  add_inst(3, load_const(1, 7, 0));
  add_inst(3, out_reg(1));                        expect_out(3, 7);
  add_inst(3, branch(opc_jump_zero, 1, 7, 12));
  add_inst(3, out_imm(30));
  add_inst(3, out_imm(29));
  add_inst(3, out_imm(20));                       expect_out(3, 20);
  add_inst(3, branch(opc_jump_zero, 1, 6, 12));
  add_inst(3, out_imm(21));                       expect_out(3, 21);
  add_inst(3, branch(opc_jump_nonzero, 1, 6, 12));
  add_inst(3, out_imm(28));
  add_inst(3, out_imm(27));
  add_inst(3, out_imm(22));                       expect_out(3, 22);
  add_inst(3, branch(opc_jump_nonzero, 1, 7, 12));
  add_inst(3, out_imm(23));                       expect_out(3, 23);

  // Jump-and-link, relative and absolute.
  add_inst(4, out_imm(5));                        expect_out(4, 5);
  add_inst(4, jump_link_imm(2, 12));
  add_inst(4, out_imm(30));
  add_inst(4, out_imm(29));
  add_inst(4, out_reg(2));                        expect_out(4, 8);
  add_inst(4, load_const(3, 32, 0));
  add_inst(4, jump_link_reg(4, 3));
  add_inst(4, out_imm(31));
  add_inst(4, out_reg(4));                        expect_out(4, 28);
  add_inst(4, out_imm(6));                        expect_out(4, 6);

  // The first program again, with ready toggling at random.
  for (k = 0; k < prog_len[0]; k++) begin
    add_inst(5, prog_inst[0][k]);
  end
  for (k = 0; k < exp_len[0]; k++) begin
    expect_out(5, prog_exp[0][k]);
  end
  random_ready[5] = 1'b1;
endtask

//--- verification/agp32_tb.sv
`timescale 1ns/1ps

module agp32_tb;
  import agp32_pkg::*;

  localparam int num_programs = 6;
  localparam int max_inst = 32;
  localparam int max_out = 16;
  localparam int reset_cycles = 8;
  localparam int out_timeout = 200;
  localparam int drain_cycles = 30;
  localparam int input_value = 2;

  logic clk;
  logic reset;
  logic ready;
  logic [31:0] inst_rdata;
  logic [1:0] data_in;
  logic [31:0] pc;
  logic [9:0] data_out;

  logic [31:0] prog_inst [num_programs][max_inst];
  int prog_len [num_programs];
  logic [31:0] prog_exp [num_programs][max_out];
  int exp_len [num_programs];
  logic random_ready [num_programs];
  logic [31:0] rng_state;

  agp32_core DUT (
    .clk(clk),
    .reset(reset),
    .ready(ready),
    .inst_rdata(inst_rdata),
    .data_in(data_in),
    .pc(pc),
    .data_out(data_out)
  );

  always #4 clk = ~clk;

  // Bit 31 W flag, 30:25 W, 24 constant, 23 A flag, 22:17 A, 16 B flag, 15:10 B.
  function automatic logic [31:0] encode(input int opc, input int func, input int w,
                                         input bit wi, input int a, input bit ai,
                                         input int b, input bit bi);
    logic [31:0] word;
    word = '0;
    word[31] = wi;
    word[30:25] = w[5:0];
    word[23] = ai;
    word[22:17] = a[5:0];
    word[16] = bi;
    word[15:10] = b[5:0];
    word[9:6] = func[3:0];
    word[5:0] = opc[5:0];
    return word;
  endfunction

  function automatic logic [31:0] alu_rr(input int func, input int w, input int a, input int b);
    return encode(0, func, w, 0, a, 0, b, 0);
  endfunction

  function automatic logic [31:0] alu_ri(input int func, input int w, input int a, input int b);
    return encode(0, func, w, 0, a, 0, b, 1);
  endfunction

  function automatic logic [31:0] alu_ii(input int func, input int w, input int a, input int b);
    return encode(0, func, w, 0, a, 1, b, 1);
  endfunction

  function automatic logic [31:0] shift_ri(input int mode, input int w, input int a,
                                           input int b);
    return encode(1, mode, w, 0, a, 0, b, 1);
  endfunction

  // Output instructions also write r63, which no program reads.
  function automatic logic [31:0] out_reg(input int r);
    return encode(6, 15, 63, 0, 0, 1, r, 0);
  endfunction

  function automatic logic [31:0] out_imm(input int v);
    return encode(6, 15, 63, 0, 0, 1, v, 1);
  endfunction

  function automatic logic [31:0] read_input(input int w);
    return encode(7, 0, w, 0, 0, 1, 0, 1);
  endfunction

  function automatic logic [31:0] jump_link_imm(input int w, input int offset);
    return encode(9, 0, w, 0, offset, 1, 0, 0);
  endfunction

  function automatic logic [31:0] jump_link_reg(input int w, input int r);
    return encode(9, 15, w, 0, r, 0, 0, 0);
  endfunction

  // Tests A minus an immediate B and jumps by the immediate offset in W.
  function automatic logic [31:0] branch(input int opc, input int a, input int b,
                                         input int offset);
    return encode(opc, 2, offset, 1, a, 0, b, 1);
  endfunction

  function automatic logic [31:0] load_const(input int w, input int value, input bit neg);
    logic [31:0] v;
    v = value;
    return {1'b1, w[5:0], 1'b1, neg, v[22:0]};
  endfunction

  function automatic logic [31:0] load_upper(input int w, input int upper);
    logic [31:0] u;
    u = upper;
    return {1'b0, w[5:0], 1'b1, 15'd0, u[8:0]};
  endfunction

  task automatic add_inst(input int p, input logic [31:0] word);
    prog_inst[p][prog_len[p]] = word;
    prog_len[p]++;
  endtask

  task automatic expect_out(input int p, input logic [31:0] value);
    prog_exp[p][exp_len[p]] = value;
    exp_len[p]++;
  endtask

  `include "agp32_programs.svh"

  function automatic logic next_ready();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state[16];
  endfunction

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("Mismatch at %0t ns: %s, got %0d, expected %0d", $time, what, actual, expected);
      $display("Result: FAILED");
      $fatal(1);
    end
  endtask

  // Called on a falling edge, after the outputs have been sampled.
  task automatic drive_inputs(input int p);
    int idx;
    idx = pc >> 2;
    if (idx < prog_len[p]) begin
      inst_rdata = prog_inst[p][idx];
    end else begin
      inst_rdata = nop_inst;
    end
    ready = random_ready[p] ? next_ready() : 1'b1;
    data_in = input_value;
  endtask

  task automatic run_program(input int p);
    int got;
    int waited;
    logic [9:0] last;
    @(negedge clk);
    reset = 1'b1;
    drive_inputs(p);
    repeat (reset_cycles) begin
      @(negedge clk);
      drive_inputs(p);
    end
    check_value(pc, 0, "pc after reset");
    check_value({22'd0, data_out}, 0, "data_out after reset");
    reset = 1'b0;
    got = 0;
    waited = 0;
    last = data_out;
    while (got < exp_len[p]) begin
      @(negedge clk);
      if (data_out !== last) begin
        check_value({22'd0, data_out}, prog_exp[p][got],
                    $sformatf("program %0d output %0d", p, got));
        last = data_out;
        got++;
        waited = 0;
      end else begin
        waited++;
        if (waited > out_timeout) begin
          $display("Timeout: program %0d produced no output %0d within %0d cycles",
                   p, got, out_timeout);
          $display("Result: FAILED");
          $fatal(1);
        end
      end
      drive_inputs(p);
    end
    // Nothing else may appear once the sequence is complete.
    repeat (drain_cycles) begin
      @(negedge clk);
      check_value({22'd0, data_out}, {22'd0, last},
                  $sformatf("program %0d extra output", p));
      drive_inputs(p);
    end
  endtask

  initial begin
    int p;
    clk = 1'b0;
    reset = 1'b1;
    ready = 1'b1;
    inst_rdata = nop_inst;
    data_in = input_value;
    rng_state = 32'd3;
    fill_program_table();
    for (p = 0; p < num_programs; p++) begin
      run_program(p);
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule

//--- build.f
+incdir+verification
source/agp32_pkg.sv
source/agp32_pipe_reg.sv
source/agp32_regfile.sv
source/agp32_alu.sv
source/agp32_fetch.sv
source/agp32_decode.sv
source/agp32_execute.sv
source/agp32_writeback.sv
source/agp32_core.sv
verification/agp32_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary -Wno-fatal -f build.f --top-module agp32_tb -o agp32_sim \
  && ./obj_dir/agp32_sim | tee /dev/stderr | grep -q "Result: PASSED" \
  || exit 1
